// ==== Makefile ====
TOP := line_table_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "SIMULATION FAILED" sim.log

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
+incdir+include
rtl/line_table_pkg.sv
rtl/code_buffer.sv
rtl/opcode_sequencer.sv
rtl/abstract_machine.sv
rtl/line_table_accelerator.sv
test/line_table_tb.sv

// ==== include/line_table_defs.svh ====
// Register map, bus lane codes and DWARF opcode values, included by the RTL and the testbench
`ifndef LINE_TABLE_DEFS_SVH
`define LINE_TABLE_DEFS_SVH

// Lane codes on data_write and data_read
`define RW_8_BIT  2'h0
`define RW_16_BIT 2'h1
`define RW_32_BIT 2'h2
`define RW_NONE   2'h3

// Memory-mapped register addresses
`define REG_PROGRAM_HEADER    6'h0
`define REG_PROGRAM_CODE      6'h1
`define REG_AM_ADDRESS        6'h2
`define REG_AM_FILE           6'h3
`define REG_AM_LINE_COL_FLAGS 6'h4
`define REG_STATUS            6'h5

// DWARF v5 standard opcodes
`define DW_LNS_COPY               8'h01
`define DW_LNS_ADVANCE_PC         8'h02
`define DW_LNS_ADVANCE_LINE       8'h03
`define DW_LNS_SET_FILE           8'h04
`define DW_LNS_SET_COLUMN         8'h05
`define DW_LNS_NEGATE_STMT        8'h06
`define DW_LNS_SET_BASIC_BLOCK    8'h07
`define DW_LNS_FIXED_ADVANCE_PC   8'h09
`define DW_LNS_SET_PROLOGUE_END   8'h0a
`define DW_LNS_SET_EPILOGUE_BEGIN 8'h0b
`define DW_LNS_SET_ISA            8'h0c

// Extended opcode prefix and the one extended opcode that is executed
`define DW_EXTENDED_START   8'h00
`define DW_LNE_END_SEQUENCE 8'h01

`endif

// ==== rtl/abstract_machine.sv ====
// DWARF line-table abstract machine registers, updated by commands from the opcode sequencer
module abstract_machine
    import line_table_pkg::*;
(
    input  logic        clk,
    input  logic        reset_this_cycle,
    input  logic        header_write,
    input  bus_word_t   header_data,
    input  am_cmd_t     am_cmd,
    input  operand_t    operand,
    output am_address_t address_out,
    output am_file_t    file_out,
    output am_line_t    line_out,
    output am_column_t  column_out,
    output logic [4:0]  flags_out,
    output logic        default_is_stmt
);
    logic     restore;
    logic     is_stmt;
    logic     basic_block;
    logic     end_sequence;
    logic     prologue_end;
    logic     epilogue_begin;
    operand_t adder_src;
    operand_t adder_sum;

    // Start of a new sequence, with line and file counting from 1
    assign restore = reset_this_cycle || header_write || am_cmd.clear_sequence;

    // Address and line advances never execute together, so they share one adder
    assign adder_src = am_cmd.add_address ? {address_out, 1'b0} : {12'h0, line_out};
    assign adder_sum = adder_src + operand;

    always_ff @(posedge clk) begin
        if (reset_this_cycle) default_is_stmt <= 1'b0;
        else if (header_write) default_is_stmt <= header_data[0];
    end

    always_ff @(posedge clk) begin
        if (restore) begin
            address_out <= '0;
            file_out    <= 16'd1;
            line_out    <= 16'd1;
            column_out  <= '0;
        end else begin
            if (am_cmd.add_address) address_out <= adder_sum[27:1];
            if (am_cmd.add_line) line_out <= adder_sum[15:0];
            if (am_cmd.set_file) file_out <= operand[15:0];
            if (am_cmd.set_column) column_out <= operand[9:0];
        end
    end

    // The header write sees the new default on the same edge, so it takes the bus bit directly
    always_ff @(posedge clk) begin
        if (reset_this_cycle) is_stmt <= 1'b0;
        else if (header_write) is_stmt <= header_data[0];
        else if (am_cmd.clear_sequence) is_stmt <= default_is_stmt;
        else if (am_cmd.negate_stmt) is_stmt <= !is_stmt;
    end

    // These three flags last for one row only
    always_ff @(posedge clk) begin
        if (restore || am_cmd.clear_row_flags) begin
            basic_block    <= 1'b0;
            prologue_end   <= 1'b0;
            epilogue_begin <= 1'b0;
        end else begin
            if (am_cmd.set_basic_block) basic_block <= 1'b1;
            if (am_cmd.set_prologue_end) prologue_end <= 1'b1;
            if (am_cmd.set_epilogue_begin) epilogue_begin <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (restore) end_sequence <= 1'b0;
        else if (am_cmd.set_end_sequence) end_sequence <= 1'b1;
    end

    // Bit order matches the flag field of the line/column/flags register
    assign flags_out = {epilogue_begin, prologue_end, end_sequence, basic_block, is_stmt};

endmodule

// ==== rtl/code_buffer.sv ====
// Program code buffer that holds the last code write and presents its bytes in lane order
`include "line_table_defs.svh"

module code_buffer
    import line_table_pkg::*;
(
    input  logic       clk,
    input  logic       reset_this_cycle,
    input  logic       header_write,
    input  logic       code_write,
    input  rw_lanes_t  code_lanes,
    input  bus_word_t  code_data,
    input  logic       consume,
    output code_byte_t current_byte,
    output logic       byte_valid
);
    bus_word_t  buffer;
    logic [2:0] lane_count;
    logic [2:0] byte_count;
    logic [2:0] byte_ptr;

    always_comb begin
        case (code_lanes)
            `RW_8_BIT:  lane_count = 3'd1;
            `RW_16_BIT: lane_count = 3'd2;
            `RW_32_BIT: lane_count = 3'd4;
            default:    lane_count = 3'd0;
        endcase
    end

    // Lanes that were not written are zeroed
    always_ff @(posedge clk) begin
        if (code_write) begin
            case (code_lanes)
                `RW_8_BIT:  buffer <= {24'h0, code_data[7:0]};
                `RW_16_BIT: buffer <= {16'h0, code_data[15:0]};
                default:    buffer <= code_data;
            endcase
        end
    end

    // The pointer needs a third bit to say that all four bytes are used up
    always_ff @(posedge clk) begin
        if (reset_this_cycle || header_write) begin
            byte_count <= 3'd0;
            byte_ptr   <= 3'd0;
        end else if (code_write) begin
            byte_count <= lane_count;
            byte_ptr   <= 3'd0;
        end else if (consume) begin
            byte_ptr <= byte_ptr + 3'd1;
        end
    end

    assign current_byte = buffer[byte_ptr[1:0]*8 +: 8];
    assign byte_valid   = byte_ptr < byte_count;

    // The sequencer may only take a byte that this buffer offers
    consume_needs_byte: assert property (@(posedge clk) disable iff (reset_this_cycle)
        consume |-> byte_valid);

endmodule

// ==== rtl/line_table_accelerator.sv ====
// Top level of the DWARF v5 line-table accelerator, attached to the host's byte-laned register bus
`include "line_table_defs.svh"

module line_table_accelerator
    import line_table_pkg::*;
(
    input  logic      clk,
    input  logic      reset_this_cycle,
    input  reg_addr_t address,
    input  bus_word_t data_in,
    input  rw_lanes_t data_write,
    input  rw_lanes_t data_read,
    output bus_word_t data_out,
    output logic      data_ready,
    output logic      interrupt
);
    logic        host_write;
    logic        header_write;
    logic        code_write;
    logic        status_write;
    code_byte_t  current_byte;
    logic        byte_valid;
    logic        consume;
    logic        emit_row;
    am_cmd_t     am_cmd;
    operand_t    operand;
    am_address_t am_address;
    am_file_t    am_file;
    am_line_t    am_line;
    am_column_t  am_column;
    logic [4:0]  am_flags;
    logic        default_is_stmt;
    logic        status;
    bus_word_t   read_word;

    assign host_write   = data_write != `RW_NONE;
    assign header_write = host_write && address == `REG_PROGRAM_HEADER;
    assign code_write   = host_write && address == `REG_PROGRAM_CODE;
    assign status_write = host_write && address == `REG_STATUS;

    code_buffer code_buffer_i (
        .clk              (clk),
        .reset_this_cycle (reset_this_cycle),
        .header_write     (header_write),
        .code_write       (code_write),
        .code_lanes       (data_write),
        .code_data        (data_in),
        .consume          (consume),
        .current_byte     (current_byte),
        .byte_valid       (byte_valid)
    );

    opcode_sequencer opcode_sequencer_i (
        .clk              (clk),
        .reset_this_cycle (reset_this_cycle),
        .host_write       (host_write),
        .header_write     (header_write),
        .status_write     (status_write),
        .current_byte     (current_byte),
        .byte_valid       (byte_valid),
        .consume          (consume),
        .emit_row         (emit_row),
        .am_cmd           (am_cmd),
        .operand          (operand)
    );

    abstract_machine abstract_machine_i (
        .clk              (clk),
        .reset_this_cycle (reset_this_cycle),
        .header_write     (header_write),
        .header_data      (data_in),
        .am_cmd           (am_cmd),
        .operand          (operand),
        .address_out      (am_address),
        .file_out         (am_file),
        .line_out         (am_line),
        .column_out       (am_column),
        .flags_out        (am_flags),
        .default_is_stmt  (default_is_stmt)
    );

    // Status reads 1 while a row waits for the host
    always_ff @(posedge clk) begin
        if (reset_this_cycle || header_write || status_write) status <= 1'b0;
        else if (emit_row) status <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset_this_cycle || status_write) interrupt <= 1'b0;
        else if (emit_row) interrupt <= 1'b1;
    end

    always_comb begin
        case (address)
            `REG_PROGRAM_HEADER:    read_word = {31'h0, default_is_stmt};
            `REG_AM_ADDRESS:        read_word = {4'h0, am_address, 1'b0};
            `REG_AM_FILE:           read_word = {16'h0, am_file};
            `REG_AM_LINE_COL_FLAGS: read_word = {1'b0, am_flags, am_column, am_line};
            `REG_STATUS:            read_word = {31'h0, status};
            default:                read_word = '0;
        endcase
    end

    // Lanes outside the read width return zero
    assign data_out[7:0]   = data_read != `RW_NONE ? read_word[7:0] : 8'h0;
    assign data_out[15:8]  = data_read == `RW_16_BIT || data_read == `RW_32_BIT ?
                             read_word[15:8] : 8'h0;
    assign data_out[31:16] = data_read == `RW_32_BIT ? read_word[31:16] : 16'h0;
    assign data_ready      = 1'b1;

    // The interrupt is only raised together with a pending row in the status register
    irq_with_status: assert property (@(posedge clk) disable iff (reset_this_cycle)
        $rose(interrupt) |-> status);

endmodule

// ==== rtl/line_table_pkg.sv ====
// Shared types of the line-table accelerator, imported by the RTL modules and the testbench
package line_table_pkg;

    typedef logic [5:0]  reg_addr_t;
    typedef logic [1:0]  rw_lanes_t;
    typedef logic [31:0] bus_word_t;
    typedef logic [7:0]  code_byte_t;
    typedef logic [27:0] operand_t;

    // The address is kept in halfwords since instructions are 2-byte aligned
    typedef logic [26:0] am_address_t;
    typedef logic [15:0] am_file_t;
    typedef logic [15:0] am_line_t;
    typedef logic [9:0]  am_column_t;

    typedef enum logic [3:0] {
        ps_ready,
        ps_extended_opcode,
        ps_pause_for_copy,
        ps_pause_for_end_sequence,
        ps_leb0,
        ps_leb1,
        ps_leb2,
        ps_leb3,
        ps_leb_overflow,
        ps_u16_byte0,
        ps_u16_byte1,
        ps_exec
    } parse_state_e;

    // Instruction waiting for its operand to be assembled
    typedef enum logic [2:0] {
        instr_nop,
        instr_advance_pc,
        instr_advance_line,
        instr_set_file,
        instr_set_column,
        instr_extended
    } instr_e;

    // One-cycle command pulses from the sequencer to the abstract machine
    typedef struct packed {
        logic add_address;
        logic add_line;
        logic set_file;
        logic set_column;
        logic negate_stmt;
        logic set_basic_block;
        logic set_prologue_end;
        logic set_epilogue_begin;
        logic set_end_sequence;
        logic clear_row_flags;
        logic clear_sequence;
    } am_cmd_t;

endpackage

// ==== rtl/opcode_sequencer.sv ====
// Line-number program parser that decodes one byte per clock into abstract machine commands
`include "line_table_defs.svh"

module opcode_sequencer
    import line_table_pkg::*;
(
    input  logic       clk,
    input  logic       reset_this_cycle,
    input  logic       host_write,
    input  logic       header_write,
    input  logic       status_write,
    input  code_byte_t current_byte,
    input  logic       byte_valid,
    output logic       consume,
    output logic       emit_row,
    output am_cmd_t    am_cmd,
    output operand_t   operand
);
    parse_state_e state;
    parse_state_e state_d;
    instr_e       instr;
    instr_e       instr_d;
    logic         leb_signed;
    logic         leb_signed_d;
    logic         paused;
    logic         exec_now;
    logic         parse;
    logic         leb_last;
    logic         sign_fill;

    // Host writes take the whole cycle, so nothing is parsed or executed alongside them
    assign paused    = state == ps_pause_for_copy || state == ps_pause_for_end_sequence;
    assign exec_now  = !host_write && state == ps_exec;
    assign parse     = !host_write && !paused && state != ps_exec && byte_valid;
    assign consume   = parse;
    assign leb_last  = !current_byte[7];
    assign sign_fill = leb_signed && current_byte[6];

    always_comb begin
        state_d      = state;
        instr_d      = instr;
        leb_signed_d = leb_signed;
        emit_row     = 1'b0;
        am_cmd       = '0;
        if (status_write) begin
            // The host has taken the row, so drop the per-row flags and resume
            state_d                = ps_ready;
            instr_d                = instr_nop;
            am_cmd.clear_row_flags = paused;
            am_cmd.clear_sequence  = state == ps_pause_for_end_sequence;
        end else if (exec_now) begin
            am_cmd.add_address = instr == instr_advance_pc;
            am_cmd.add_line    = instr == instr_advance_line;
            am_cmd.set_file    = instr == instr_set_file;
            am_cmd.set_column  = instr == instr_set_column;
            state_d            = instr == instr_extended ? ps_extended_opcode : ps_ready;
        end else if (parse) begin
            case (state)
                ps_ready: begin
                    instr_d      = instr_nop;
                    leb_signed_d = current_byte == `DW_LNS_ADVANCE_LINE;
                    case (current_byte)
                        `DW_LNS_COPY: begin
                            emit_row = 1'b1;
                            state_d  = ps_pause_for_copy;
                        end
                        `DW_LNS_ADVANCE_PC: begin
                            instr_d = instr_advance_pc;
                            state_d = ps_leb0;
                        end
                        `DW_LNS_ADVANCE_LINE: begin
                            instr_d = instr_advance_line;
                            state_d = ps_leb0;
                        end
                        `DW_LNS_SET_FILE: begin
                            instr_d = instr_set_file;
                            state_d = ps_leb0;
                        end
                        `DW_LNS_SET_COLUMN: begin
                            instr_d = instr_set_column;
                            state_d = ps_leb0;
                        end
                        `DW_LNS_FIXED_ADVANCE_PC: begin
                            instr_d = instr_advance_pc;
                            state_d = ps_u16_byte0;
                        end
                        `DW_EXTENDED_START: begin
                            instr_d = instr_extended;
                            state_d = ps_leb0;
                        end
                        // The ISA operand is parsed and then thrown away
                        `DW_LNS_SET_ISA:            state_d = ps_leb0;
                        `DW_LNS_NEGATE_STMT:        am_cmd.negate_stmt = 1'b1;
                        `DW_LNS_SET_BASIC_BLOCK:    am_cmd.set_basic_block = 1'b1;
                        `DW_LNS_SET_PROLOGUE_END:   am_cmd.set_prologue_end = 1'b1;
                        `DW_LNS_SET_EPILOGUE_BEGIN: am_cmd.set_epilogue_begin = 1'b1;
                        default:                    state_d = ps_ready;
                    endcase
                end
                ps_extended_opcode: begin
                    if (current_byte == `DW_LNE_END_SEQUENCE) begin
                        emit_row                = 1'b1;
                        am_cmd.set_end_sequence = 1'b1;
                        state_d                 = ps_pause_for_end_sequence;
                    end else begin
                        state_d = ps_ready;
                    end
                end
                ps_leb0:      state_d = leb_last ? ps_exec : ps_leb1;
                ps_leb1:      state_d = leb_last ? ps_exec : ps_leb2;
                ps_leb2:      state_d = leb_last ? ps_exec : ps_leb3;
                ps_u16_byte0: state_d = ps_u16_byte1;
                ps_u16_byte1: state_d = ps_exec;
                // Groups past the fourth would overflow 28 bits, so they are skipped
                default:      state_d = leb_last ? ps_exec : ps_leb_overflow;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_this_cycle || header_write) begin
            state      <= ps_ready;
            instr      <= instr_nop;
            leb_signed <= 1'b0;
        end else begin
            state      <= state_d;
            instr      <= instr_d;
            leb_signed <= leb_signed_d;
        end
    end

    // LEB groups fill from the bottom, and a signed value copies bit 6 of each group upwards
    always_ff @(posedge clk) begin
        if (reset_this_cycle || header_write) begin
            operand <= '0;
        end else if (parse) begin
            case (state)
                ps_leb0:      operand <= {{21{sign_fill}}, current_byte[6:0]};
                ps_leb1:      operand <= {{14{sign_fill}}, current_byte[6:0], operand[6:0]};
                ps_leb2:      operand <= {{7{sign_fill}}, current_byte[6:0], operand[13:0]};
                ps_leb3:      operand <= {current_byte[6:0], operand[20:0]};
                ps_u16_byte0: operand <= {20'h0, current_byte};
                ps_u16_byte1: operand <= {12'h0, current_byte, operand[7:0]};
                default:      operand <= operand;
            endcase
        end
    end

    // A row comes only from an opcode byte, and parsing then holds until the host answers
    row_from_opcode: assert property (@(posedge clk) disable iff (reset_this_cycle)
        emit_row |-> (state == ps_ready || state == ps_extended_opcode) ##1 paused);

endmodule

// ==== test/line_table_tb.sv ====
// Table-driven testbench for the line-table accelerator, compiled as the simulation top from compile.f
`include "line_table_defs.svh"

module line_table_tb
    import line_table_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum {
        step_header_write,
        step_code_write,
        step_row_wait,
        step_register_check,
        step_status_write
    } step_kind_e;

    // The expected fields only matter for register checks
    typedef struct {
        step_kind_e kind;
        reg_addr_t  addr;
        rw_lanes_t  lanes;
        bus_word_t  data;
        bus_word_t  expect_data;
        logic       expect_irq;
        int         gap;
    } step_t;

    logic        clk;
    logic        reset_this_cycle;
    reg_addr_t   address;
    bus_word_t   data_in;
    rw_lanes_t   data_write;
    rw_lanes_t   data_read;
    bus_word_t   data_out;
    logic        data_ready;
    logic        interrupt;
    step_t       steps[$];
    logic [31:0] lfsr_state;
    int          error_count;
    int          check_count;

    line_table_accelerator line_table_accelerator_i (
        .clk              (clk),
        .reset_this_cycle (reset_this_cycle),
        .address          (address),
        .data_in          (data_in),
        .data_write       (data_write),
        .data_read        (data_read),
        .data_out         (data_out),
        .data_ready       (data_ready),
        .interrupt        (interrupt)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
    function automatic int next_random_bits(input int count);
        int   value;
        logic feedback;
        value = 0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = (value << 1) | int'(feedback);
        end
        return value;
    endfunction

    // Line in bits 15:0, column in 25:16, then the five flags from bit 26 up
    function automatic bus_word_t line_word(input int line, input int column, input logic is_stmt,
                                            input logic basic_block, input logic end_sequence,
                                            input logic prologue_end, input logic epilogue_begin);
        return {1'b0, epilogue_begin, prologue_end, end_sequence, basic_block, is_stmt,
                column[9:0], line[15:0]};
    endfunction

    task automatic queue_step(input step_kind_e kind, input reg_addr_t addr,
                              input rw_lanes_t lanes, input bus_word_t data,
                              input bus_word_t expect_data, input logic expect_irq);
        step_t s;
        s.kind        = kind;
        s.addr        = addr;
        s.lanes       = lanes;
        s.data        = data;
        s.expect_data = expect_data;
        s.expect_irq  = expect_irq;
        s.gap         = kind == step_code_write ? 8 + next_random_bits(3) : 0;
        steps.push_back(s);
    endtask

    task automatic queue_code_write(input rw_lanes_t lanes, input bus_word_t data);
        queue_step(step_code_write, `REG_PROGRAM_CODE, lanes, data, '0, 1'b0);
    endtask

    task automatic queue_check(input reg_addr_t addr, input rw_lanes_t lanes,
                               input bus_word_t expect_data, input logic expect_irq);
        queue_step(step_register_check, addr, lanes, '0, expect_data, expect_irq);
    endtask

    // Interrupt follows status in every scenario here
    task automatic queue_state_checks(input int pc, input int file, input bus_word_t lw,
                                      input logic pending);
        queue_check(`REG_AM_ADDRESS, `RW_32_BIT, 32'(pc), pending);
        queue_check(`REG_AM_FILE, `RW_32_BIT, 32'(file), pending);
        queue_check(`REG_AM_LINE_COL_FLAGS, `RW_32_BIT, lw, pending);
        queue_check(`REG_STATUS, `RW_32_BIT, {31'h0, pending}, pending);
    endtask

    task automatic build_table();
        int   pc;
        int   line;
        int   file;
        int   column;
        logic stmt;
        queue_state_checks(0, 1, line_word(1, 0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0);
        queue_check(`REG_PROGRAM_HEADER, `RW_32_BIT, 32'h0, 1'b0);
        // advance_pc 64, advance_line +300 then -200, set_file 5, set_column 42, copy
        queue_step(step_header_write, `REG_PROGRAM_HEADER, `RW_32_BIT, 32'h1, '0, 1'b0);
        queue_check(`REG_PROGRAM_HEADER, `RW_32_BIT, 32'h1, 1'b0);
        queue_code_write(`RW_32_BIT, 32'hac03_4002);
        queue_code_write(`RW_32_BIT, 32'h7eb8_0302);
        queue_code_write(`RW_32_BIT, 32'h2a05_0504);
        queue_code_write(`RW_8_BIT, 32'hdead_be01);
        queue_step(step_row_wait, '0, `RW_NONE, '0, '0, 1'b0);
        pc = 64;
        line = 1 + 300 - 200;
        file = 5;
        column = 42;
        stmt = 1'b1;
        queue_state_checks(pc, file, line_word(line, column, stmt, 1'b0, 1'b0, 1'b0, 1'b0), 1'b1);
        queue_step(step_status_write, `REG_STATUS, `RW_8_BIT, 32'h1, '0, 1'b0);
        queue_state_checks(pc, file, line_word(line, column, stmt, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0);
        // fixed_advance_pc 0x1234, advance_pc by a four-byte LEB, set_file 7 as a five-byte LEB
        // and copy, split over 1, 2 and 4 byte writes with junk in the idle lanes
        queue_code_write(`RW_8_BIT, 32'hffff_ff09);
        queue_code_write(`RW_16_BIT, 32'ha5a5_1234);
        queue_code_write(`RW_32_BIT, 32'h9a95_ce02);
        queue_code_write(`RW_8_BIT, 32'h5a5a_5a12);
        queue_code_write(`RW_16_BIT, 32'h7777_8704);
        queue_code_write(`RW_32_BIT, 32'h0080_8080);
        queue_code_write(`RW_8_BIT, 32'heeee_ee01);
        queue_step(step_row_wait, '0, `RW_NONE, '0, '0, 1'b0);
        pc = pc + 'h1234 + 'h246_8ace;
        file = 7;
        queue_state_checks(pc, file, line_word(line, column, stmt, 1'b0, 1'b0, 1'b0, 1'b0), 1'b1);
        queue_check(`REG_AM_ADDRESS, `RW_8_BIT, 32'(pc) & 32'hff, 1'b1);
        queue_check(`REG_AM_ADDRESS, `RW_16_BIT, 32'(pc) & 32'hffff, 1'b1);
        queue_step(step_status_write, `REG_STATUS, `RW_8_BIT, 32'h1, '0, 1'b0);
        queue_check(`REG_STATUS, `RW_32_BIT, 32'h0, 1'b0);
        // negate_stmt, set_basic_block, set_prologue_end, set_epilogue_begin, copy
        queue_code_write(`RW_32_BIT, 32'h0b0a_0706);
        queue_code_write(`RW_8_BIT, 32'h5555_5501);
        queue_step(step_row_wait, '0, `RW_NONE, '0, '0, 1'b0);
        stmt = !stmt;
        queue_state_checks(pc, file, line_word(line, column, stmt, 1'b1, 1'b0, 1'b1, 1'b1), 1'b1);
        queue_step(step_status_write, `REG_STATUS, `RW_8_BIT, 32'h1, '0, 1'b0);
        queue_state_checks(pc, file, line_word(line, column, stmt, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0);
        // set_isa 5, then end_sequence behind the extended prefix
        queue_code_write(`RW_32_BIT, 32'h0100_050c);
        queue_code_write(`RW_8_BIT, 32'h3c3c_3c01);
        queue_step(step_row_wait, '0, `RW_NONE, '0, '0, 1'b0);
        queue_state_checks(pc, file, line_word(line, column, stmt, 1'b0, 1'b1, 1'b0, 1'b0), 1'b1);
        queue_step(step_status_write, `REG_STATUS, `RW_8_BIT, 32'h1, '0, 1'b0);
        queue_state_checks(0, 1, line_word(1, 0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0);
        // set_file 9 and set_column 3, then advance_line cut off after its first LEB byte
        queue_code_write(`RW_32_BIT, 32'h0305_0904);
        queue_check(`REG_AM_FILE, `RW_32_BIT, 32'd9, 1'b0);
        queue_check(`REG_AM_LINE_COL_FLAGS, `RW_32_BIT,
                    line_word(1, 3, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0);
        queue_code_write(`RW_16_BIT, 32'hc3c3_b803);
        queue_step(step_header_write, `REG_PROGRAM_HEADER, `RW_32_BIT, 32'h0, '0, 1'b0);
        queue_state_checks(0, 1, line_word(1, 0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0);
        queue_check(`REG_PROGRAM_HEADER, `RW_32_BIT, 32'h0, 1'b0);
        queue_code_write(`RW_8_BIT, 32'h0000_0001);
        queue_step(step_row_wait, '0, `RW_NONE, '0, '0, 1'b0);
        queue_state_checks(0, 1, line_word(1, 0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0), 1'b1);
        queue_step(step_status_write, `REG_STATUS, `RW_8_BIT, 32'h1, '0, 1'b0);
        queue_check(`REG_STATUS, `RW_32_BIT, 32'h0, 1'b0);
    endtask

    task automatic bus_write(input reg_addr_t addr, input rw_lanes_t lanes, input bus_word_t data);
        @(posedge clk);
        #1;
        address    = addr;
        data_in    = data;
        data_write = lanes;
        @(posedge clk);
        #1;
        data_write = `RW_NONE;
    endtask

    // Reads are combinational, so the word is taken mid-cycle
    task automatic bus_read(input reg_addr_t addr, input rw_lanes_t lanes, output bus_word_t data);
        @(posedge clk);
        #1;
        address   = addr;
        data_read = lanes;
        @(negedge clk);
        data = data_out;
    endtask

    task automatic run_step(input int idx);
        step_t     s;
        bus_word_t value;
        int        cycles;
        s = steps[idx];
        case (s.kind)
            step_header_write: bus_write(`REG_PROGRAM_HEADER, `RW_32_BIT, s.data);
            step_status_write: bus_write(`REG_STATUS, `RW_8_BIT, s.data);
            step_code_write: begin
                bus_write(`REG_PROGRAM_CODE, s.lanes, s.data);
                repeat (s.gap) @(posedge clk);
            end
            step_row_wait: begin
                cycles = 0;
                while (interrupt !== 1'b1 && cycles < 200) begin
                    @(negedge clk);
                    cycles++;
                end
                if (interrupt !== 1'b1) begin
                    $display("Step %0d timed out: no row was announced within 200 cycles", idx);
                    error_count++;
                end
            end
            default: begin
                bus_read(s.addr, s.lanes, value);
                check_count++;
                if (value !== s.expect_data) begin
                    $display("Error in step %0d: data_out = 0x%h, expected 0x%h (register 0x%h)",
                             idx, value, s.expect_data, s.addr);
                    error_count++;
                end
                if (interrupt !== s.expect_irq) begin
                    $display("Error in step %0d: interrupt = 0x%h, expected 0x%h",
                             idx, interrupt, s.expect_irq);
                    error_count++;
                end
                if (data_ready !== 1'b1) begin
                    $display("Error in step %0d: data_ready = 0x%h, expected 0x1", idx, data_ready);
                    error_count++;
                end
            end
        endcase
    endtask

    initial begin
        reset_this_cycle = 1'b1;
        address          = '0;
        data_in          = '0;
        data_write       = `RW_NONE;
        data_read        = `RW_NONE;
        error_count      = 0;
        check_count      = 0;
        lfsr_state       = 32'he281_4fd4;
        build_table();
        repeat (8) @(posedge clk);
        #1;
        reset_this_cycle = 1'b0;
        foreach (steps[i]) begin
            run_step(i);
        end
        $display("Register checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
